// ==== Makefile ====
SIM := obj_dir/Vtb_fx_alu

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary -j 0 --top-module tb_fx_alu -f project.f

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== project.f ====
src/fx_alu_pkg.sv
src/fx_addsub.sv
src/fx_mult.sv
src/alu_ctrl.sv
src/alu_datapath.sv
src/fx_alu.sv
test/tb_fx_alu.sv

// ==== src/alu_ctrl.sv ====
`timescale 1ns/1ps

module alu_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  fx_alu_pkg::op_t     i_inst,
    output logic                o_busy,
    output logic                o_valid,
    output fx_alu_pkg::src_t    o_sel_a,
    output fx_alu_pkg::src_t    o_sel_b,
    output fx_alu_pkg::unit_t   o_unit,
    output logic                o_save_prod,
    output logic                o_save_result
);

    import fx_alu_pkg::*;

    state_t state;
    state_t next_state;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_START;
        end else begin
            state <= next_state;
        end
    end

    // sequence for one instruction
    always_comb begin
        next_state = state;
        case (state)
            ST_START:  next_state = ST_READY;
            ST_READY:  next_state = ST_WAIT;
            ST_WAIT:   next_state = ST_CALC;  // host sets up operands
            ST_CALC: begin
                if (i_inst == OP_MAC) begin
                    next_state = ST_MAC;
                end else begin
                    next_state = ST_FINISH;
                end
            end
            ST_MAC:    next_state = ST_FINISH;
            ST_FINISH: next_state = ST_READY;
            default:   next_state = ST_START;
        endcase
    end

    assign o_busy  = (state != ST_READY);
    assign o_valid = (state == ST_FINISH);

    // datapath strobes and selects
    always_comb begin
        o_sel_a       = SRC_DATA_A;
        o_sel_b       = SRC_DATA_B;
        o_unit        = UNIT_ZERO;
        o_save_prod   = 1'b0;
        o_save_result = 1'b0;
        case (state)
            ST_CALC: begin
                case (i_inst)
                    OP_ADD: begin
                        o_unit        = UNIT_ADD;
                        o_save_result = 1'b1;
                    end
                    OP_SUB: begin
                        o_unit        = UNIT_SUB;
                        o_save_result = 1'b1;
                    end
                    OP_MULT: begin
                        o_unit        = UNIT_MULT;
                        o_save_result = 1'b1;
                    end
                    OP_MAC: begin
                        o_unit      = UNIT_MULT;
                        o_save_prod = 1'b1;  // product first, sum next cycle
                    end
                    default: begin
                        o_unit        = UNIT_ZERO;  // unknown code gives 0
                        o_save_result = 1'b1;
                    end
                endcase
            end
            ST_MAC: begin
                // saved product plus previous result
                o_sel_a       = SRC_SAVED;
                o_sel_b       = SRC_RESULT;
                o_unit        = UNIT_ADD;
                o_save_result = 1'b1;
            end
            default: begin
                o_unit = UNIT_ZERO;
            end
        endcase
    end

endmodule

// ==== src/alu_datapath.sv ====
`timescale 1ns/1ps

module alu_datapath #(
    parameter int FRAC_W = 10
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  fx_alu_pkg::fx_t     i_data_a,
    input  fx_alu_pkg::fx_t     i_data_b,
    input  fx_alu_pkg::src_t    i_sel_a,
    input  fx_alu_pkg::src_t    i_sel_b,
    input  fx_alu_pkg::unit_t   i_unit,
    input  logic                i_save_prod,
    input  logic                i_save_result,
    output fx_alu_pkg::fx_t     o_data
);

    import fx_alu_pkg::*;

    fx_t saved_q;   // product waiting for the mac add
    fx_t result_q;
    fx_t op_a;
    fx_t op_b;
    fx_t addsub_out;
    fx_t mult_out;
    fx_t unit_out;

    function automatic fx_t pick_src(
        input src_t sel,
        input fx_t  data_a,
        input fx_t  data_b,
        input fx_t  saved,
        input fx_t  result
    );
        fx_t val;
        case (sel)
            SRC_DATA_A: val = data_a;
            SRC_DATA_B: val = data_b;
            SRC_SAVED:  val = saved;
            default:    val = result;
        endcase
        return val;
    endfunction

    assign op_a = pick_src(i_sel_a, i_data_a, i_data_b, saved_q, result_q);
    assign op_b = pick_src(i_sel_b, i_data_a, i_data_b, saved_q, result_q);

    // add and subtract share one unit
    fx_addsub u_addsub (
        .i_a   (op_a),
        .i_b   (op_b),
        .i_sub (i_unit == UNIT_SUB),
        .o_sum (addsub_out)
    );

    fx_mult #(
        .FRAC_W (FRAC_W)
    ) u_mult (
        .i_a    (op_a),
        .i_b    (op_b),
        .o_prod (mult_out)
    );

    always_comb begin
        case (i_unit)
            UNIT_ADD, UNIT_SUB: unit_out = addsub_out;
            UNIT_MULT:          unit_out = mult_out;
            default:            unit_out = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            saved_q  <= '0;
            result_q <= '0;
        end else begin
            if (i_save_prod) saved_q <= unit_out;
            if (i_save_result) result_q <= unit_out;  // held across instructions
        end
    end

    assign o_data = result_q;

endmodule

// ==== src/fx_addsub.sv ====
`timescale 1ns/1ps

module fx_addsub (
    input  fx_alu_pkg::fx_t i_a,
    input  fx_alu_pkg::fx_t i_b,
    input  logic            i_sub,  // 1 selects a - b
    output fx_alu_pkg::fx_t o_sum
);

    import fx_alu_pkg::*;

    // one extra bit so overflow shows up as a mismatch of the top two bits
    logic [DATA_W:0] wide_a;
    logic [DATA_W:0] wide_b;
    logic [DATA_W:0] wide_sum;
    logic            ovf;

    assign wide_a = {i_a[DATA_W-1], i_a};
    assign wide_b = {i_b[DATA_W-1], i_b};

    always_comb begin
        if (i_sub) begin
            wide_sum = wide_a - wide_b;
        end else begin
            wide_sum = wide_a + wide_b;
        end
    end

    assign ovf = wide_sum[DATA_W] ^ wide_sum[DATA_W-1];

    // saturate toward the true sign, which the extra bit still holds
    always_comb begin
        if (!ovf) begin
            o_sum = wide_sum[DATA_W-1:0];
        end else if (wide_sum[DATA_W]) begin
            o_sum = FX_MIN;  // negative overflow
        end else begin
            o_sum = FX_MAX;  // positive overflow
        end
    end

endmodule

// ==== src/fx_alu.sv ====
`timescale 1ns/1ps

module fx_alu #(
    parameter int FRAC_W = 10  // fraction bits of the word
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  fx_alu_pkg::fx_t  i_data_a,
    input  fx_alu_pkg::fx_t  i_data_b,
    input  fx_alu_pkg::op_t  i_inst,
    output logic             o_busy,
    output logic             o_valid,
    output fx_alu_pkg::fx_t  o_data
);

    import fx_alu_pkg::*;

    src_t  sel_a;
    src_t  sel_b;
    unit_t unit;
    logic  save_prod;
    logic  save_result;

    alu_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_inst        (i_inst),
        .o_busy        (o_busy),
        .o_valid       (o_valid),
        .o_sel_a       (sel_a),
        .o_sel_b       (sel_b),
        .o_unit        (unit),
        .o_save_prod   (save_prod),
        .o_save_result (save_result)
    );

    alu_datapath #(
        .FRAC_W (FRAC_W)
    ) u_datapath (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_data_a      (i_data_a),
        .i_data_b      (i_data_b),
        .i_sel_a       (sel_a),
        .i_sel_b       (sel_b),
        .i_unit        (unit),
        .i_save_prod   (save_prod),
        .i_save_result (save_result),
        .o_data        (o_data)
    );

endmodule

// ==== src/fx_alu_pkg.sv ====
package fx_alu_pkg;

    localparam int DATA_W = 16; // word width, integer plus fraction bits

    // signed fixed-point word and its full-width product
    typedef logic signed [DATA_W-1:0]   fx_t;
    typedef logic signed [2*DATA_W-1:0] prod_t;

    // saturation bounds of the word
    localparam fx_t FX_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam fx_t FX_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // instruction codes, anything else returns zero
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MULT = 4'd2,
        OP_MAC  = 4'd3
    } op_t;

    typedef enum logic [1:0] {
        SRC_DATA_A,
        SRC_DATA_B,
        SRC_SAVED,  // product kept for mac
        SRC_RESULT  // current o_data
    } src_t;

    typedef enum logic [1:0] {
        UNIT_ADD,
        UNIT_SUB,
        UNIT_MULT,
        UNIT_ZERO
    } unit_t;

    typedef enum logic [2:0] {
        ST_START,
        ST_READY,
        ST_WAIT,
        ST_CALC,
        ST_MAC,
        ST_FINISH
    } state_t;

endpackage

// ==== src/fx_mult.sv ====
`timescale 1ns/1ps

module fx_mult #(
    parameter int FRAC_W = 10
) (
    input  fx_alu_pkg::fx_t i_a,
    input  fx_alu_pkg::fx_t i_b,
    output fx_alu_pkg::fx_t o_prod
);

    import fx_alu_pkg::*;

    localparam int INT_W   = DATA_W - FRAC_W;
    localparam int PINT_W  = 2 * DATA_W - 2 * FRAC_W; // integer field of the product
    localparam int INT_MAX = (1 << (INT_W - 1)) - 1;
    localparam int INT_MIN = -(1 << (INT_W - 1));

    prod_t                     full;
    logic signed [PINT_W-1:0]  int_part;
    fx_t                       trunc;
    logic                      round_up;

    assign full     = prod_t'(i_a) * prod_t'(i_b);
    assign int_part = full[2*DATA_W-1:2*FRAC_W];
    assign trunc    = full[DATA_W+FRAC_W-1:FRAC_W];

    // discarded fraction >= one half exactly when its top bit is set
    assign round_up = full[FRAC_W-1];

    always_comb begin
        if (int'(int_part) > INT_MAX) begin
            o_prod = FX_MAX;
        end else if (int'(int_part) <= INT_MIN) begin
            o_prod = FX_MIN;
        end else if (round_up) begin
            // rounding the top value up would wrap
            if (trunc == FX_MAX) begin
                o_prod = FX_MAX;
            end else begin
                o_prod = trunc + fx_t'(1);
            end
        end else begin
            o_prod = trunc;
        end
    end

endmodule

// ==== test/tb_fx_alu.sv ====
`timescale 1ns/1ps

module tb_fx_alu;

    import fx_alu_pkg::*;

    localparam int FRAC_W    = 10;
    localparam int TABLE_LEN = 25;
    localparam int N_RANDOM  = 200;
    localparam int TIMEOUT   = (TABLE_LEN + N_RANDOM) * 8 + 50;
    localparam longint INT_HI = (longint'(1) << (DATA_W - FRAC_W - 1)) - 1;   // 31
    localparam longint INT_LO = -(longint'(1) << (DATA_W - FRAC_W - 1));      // -32

    logic clk = 1'b0;
    logic rst_n;
    fx_t  data_a;
    fx_t  data_b;
    op_t  inst;
    logic busy;
    logic valid;
    fx_t  data;

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    fx_t  model_last;  // model's copy of o_data for mac

    op_t  tbl_op  [TABLE_LEN];
    fx_t  tbl_a   [TABLE_LEN];
    fx_t  tbl_b   [TABLE_LEN];
    fx_t  tbl_exp [TABLE_LEN];

    fx_alu #(
        .FRAC_W (FRAC_W)
    ) u_fx_alu (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_inst   (inst),
        .o_busy   (busy),
        .o_valid  (valid),
        .o_data   (data)
    );

    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_fx(input string name, input fx_t got, input fx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic longint clamp(input longint v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // full product, saturate on integer part, else round half up
    function automatic longint mult_round(input fx_t a, input fx_t b);
        longint p;
        longint ip;
        longint r;
        p  = longint'(a) * longint'(b);
        ip = p >>> (2 * FRAC_W);
        if (ip > INT_HI) return 32767;
        if (ip <= INT_LO) return -32768;
        r = (p + (longint'(1) <<< (FRAC_W - 1))) >>> FRAC_W;
        return clamp(r);
    endfunction

    function automatic fx_t model_op(input op_t op, input fx_t a, input fx_t b, input fx_t last);
        longint r;
        case (op)
            OP_ADD:  r = clamp(longint'(a) + longint'(b));
            OP_SUB:  r = clamp(longint'(a) - longint'(b));
            OP_MULT: r = mult_round(a, b);
            OP_MAC:  r = clamp(mult_round(a, b) + longint'(last));
            default: r = 0;
        endcase
        return fx_t'(r);
    endfunction

    task automatic set_entry(input int i, input op_t op, input fx_t a, input fx_t b,
                             input fx_t exp);
        tbl_op[i]  = op;
        tbl_a[i]   = a;
        tbl_b[i]   = b;
        tbl_exp[i] = exp;
    endtask

    task automatic load_table();
        set_entry(0,  OP_ADD,  16'h0400, 16'h0800, 16'h0C00);
        set_entry(1,  OP_ADD,  16'h7000, 16'h2000, 16'h7FFF);  // positive overflow
        set_entry(2,  OP_SUB,  16'h0C00, 16'h0400, 16'h0800);
        set_entry(3,  OP_SUB,  16'h8000, 16'h0400, 16'h8000);  // negative overflow
        set_entry(4,  OP_ADD,  16'h9000, 16'h9000, 16'h8000);
        set_entry(5,  OP_SUB,  16'h0400, 16'h0C00, 16'hF800);
        set_entry(6,  OP_MULT, 16'h0600, 16'h0600, 16'h0900);  // 1.5 * 1.5
        set_entry(7,  OP_MULT, 16'hFA00, 16'h0600, 16'hF700);
        set_entry(8,  OP_MULT, 16'h0001, 16'h0200, 16'h0001);  // +half rounds up
        set_entry(9,  OP_MULT, 16'hFFFF, 16'h0200, 16'h0000);  // -half rounds to zero
        set_entry(10, OP_MULT, 16'h2000, 16'h0400, 16'h2000);
        set_entry(11, OP_MULT, 16'h4000, 16'h0800, 16'h7FFF);  // integer part 32
        set_entry(12, OP_MULT, 16'hC000, 16'h0800, 16'h8000);  // integer part -32
        set_entry(13, OP_MULT, 16'h0001, 16'h0001, 16'h0000);
        set_entry(14, OP_ADD,  16'h0400, 16'h0000, 16'h0400);  // base 1.0
        set_entry(15, OP_MAC,  16'h0800, 16'h0400, 16'h0C00);
        set_entry(16, OP_MAC,  16'h0600, 16'h0600, 16'h1500);  // 3 + 2.25
        set_entry(17, OP_ADD,  16'hFC00, 16'h0000, 16'hFC00);  // new base -1.0
        set_entry(18, OP_MAC,  16'h0400, 16'h0200, 16'hFE00);
        set_entry(19, OP_MAC,  16'h4000, 16'h0800, 16'h7DFF);  // saturated product added
        set_entry(20, OP_MAC,  16'h1000, 16'h1000, 16'h7FFF);
        set_entry(21, op_t'(4'd4),  16'h1234, 16'h5678, 16'h0000);
        set_entry(22, op_t'(4'd9),  16'h7FFF, 16'h7FFF, 16'h0000);
        set_entry(23, OP_MAC,  16'h0400, 16'h0400, 16'h0400);  // accumulates onto zero
        set_entry(24, op_t'(4'd15), 16'h8000, 16'h0001, 16'h0000);
    endtask

    // starts on a falling edge inside the ready cycle
    task automatic run_op(input op_t op, input fx_t a, input fx_t b, input fx_t exp);
        int n;
        int want;
        while (busy) @(negedge clk);
        inst   = op;
        data_a = a;
        data_b = b;
        want = (op == OP_MAC) ? 4 : 3;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_flag("o_busy", busy, 1'b1);
        end while (!valid);
        check_cycles("o_valid latency", n, want);
        check_fx("o_data", data, exp);
        @(negedge clk);
        check_flag("o_valid", valid, 1'b0);  // single cycle pulse
        check_flag("o_busy", busy, 1'b0);    // ready right after finish
    endtask

    initial begin
        logic [3:0] code;
        op_t        op;
        fx_t        a;
        fx_t        b;
        fx_t        exp;
        void'($urandom(32'h8106));
        rst_n      = 1'b0;
        data_a     = '0;
        data_b     = '0;
        inst       = OP_ADD;
        model_last = '0;
        load_table();

        repeat (2) begin
            @(negedge clk);
            check_flag("o_busy", busy, 1'b1);
            check_flag("o_valid", valid, 1'b0);
            check_fx("o_data", data, 16'h0000);
        end
        rst_n = 1'b1;
        @(negedge clk);
        while (busy) begin  // start state before the first ready
            check_flag("o_valid", valid, 1'b0);
            check_fx("o_data", data, 16'h0000);
            @(negedge clk);
        end

        for (int i = 0; i < TABLE_LEN + N_RANDOM; i++) begin
            if (i < TABLE_LEN) begin
                op  = tbl_op[i];
                a   = tbl_a[i];
                b   = tbl_b[i];
                exp = tbl_exp[i];
            end else begin
                code = ($urandom % 2 == 0) ? 4'($urandom % 4) : 4'($urandom % 16);
                op   = op_t'(code);
                a    = fx_t'($urandom);
                b    = fx_t'($urandom);
                if ($urandom % 2 == 0) a = a >>> 4;  // smaller operands avoid saturation
                if ($urandom % 2 == 0) b = b >>> 4;
                exp  = model_op(op, a, b, model_last);
            end
            run_op(op, a, b, exp);
            model_last = exp;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
